/* rv_decode_pkg.sv */
package rv_decode_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0] csr_cmd_t;  // funct3 of a SYSTEM instruction, zero when there is no csr access
  typedef logic [3:0] cause_t;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_lui,
    alu_auipc,
    alu_pass,
    alu_ill    // the word does not decode to anything we support
  } alu_op_e;

  localparam cause_t cause_illegal_inst = 4'd2;

  // supervisor
  localparam csr_addr_t csr_sstatus = 12'h100;
  localparam csr_addr_t csr_sie = 12'h104;
  localparam csr_addr_t csr_stvec = 12'h105;
  localparam csr_addr_t csr_scounteren = 12'h106;
  localparam csr_addr_t csr_sscratch = 12'h140;
  localparam csr_addr_t csr_sepc = 12'h141;
  localparam csr_addr_t csr_scause = 12'h142;
  localparam csr_addr_t csr_stval = 12'h143;
  localparam csr_addr_t csr_sip = 12'h144;
  localparam csr_addr_t csr_satp = 12'h180;

  // machine
  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_misa = 12'h301;
  localparam csr_addr_t csr_medeleg = 12'h302;
  localparam csr_addr_t csr_mideleg = 12'h303;
  localparam csr_addr_t csr_mie = 12'h304;
  localparam csr_addr_t csr_mtvec = 12'h305;
  localparam csr_addr_t csr_mstatush = 12'h310;
  localparam csr_addr_t csr_mscratch = 12'h340;
  localparam csr_addr_t csr_mepc = 12'h341;
  localparam csr_addr_t csr_mcause = 12'h342;
  localparam csr_addr_t csr_mtval = 12'h343;
  localparam csr_addr_t csr_mip = 12'h344;
  localparam csr_addr_t csr_mcycle = 12'hb00;
  localparam csr_addr_t csr_mcycleh = 12'hb80;
  localparam csr_addr_t csr_mvendorid = 12'hf11;
  localparam csr_addr_t csr_marchid = 12'hf12;
  localparam csr_addr_t csr_mimpid = 12'hf13;
  localparam csr_addr_t csr_mhartid = 12'hf14;

  // unprivileged counters
  localparam csr_addr_t csr_cycle = 12'hc00;
  localparam csr_addr_t csr_time = 12'hc01;
  localparam csr_addr_t csr_timeh = 12'hc81;

endpackage

/* rv_fetch_decode_if.sv */
`timescale 1ns/1ps

interface rv_fetch_decode_if
  import rv_decode_pkg::*;
();
  logic  valid;
  logic  ready;
  inst_t inst;
  addr_t pc;
  addr_t pnpc;  // next pc as predicted by fetch

  modport fetch(output valid, inst, pc, pnpc, input ready);
  modport decode(input valid, inst, pc, pnpc, output ready);
endinterface

/* rv_decode_rename_if.sv */
`timescale 1ns/1ps

interface rv_decode_rename_if
  import rv_decode_pkg::*;
();
  logic        valid;
  logic        ready;
  logic        is_c;
  inst_t       inst;  // always the 32-bit form, after expansion
  addr_t       pc;
  addr_t       pnpc;
  alu_op_e     alu;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [31:0] imm;
  logic        wen;
  logic        ren;
  logic        sen;
  logic        ben;
  logic        jen;
  logic        jren;
  logic        system;
  logic        ecall;
  logic        ebreak;
  logic        mret;
  csr_cmd_t    csr_cmd;
  csr_addr_t   csr;
  logic        trap;
  cause_t      cause;
  inst_t       tval;

  modport decode(
    output valid, is_c, inst, pc, pnpc, alu, rd, rs1, rs2, imm,
    output wen, ren, sen, ben, jen, jren, system, ecall, ebreak, mret, csr_cmd, csr,
    output trap, cause, tval,
    input ready
  );
  modport rename(
    input valid, is_c, inst, pc, pnpc, alu, rd, rs1, rs2, imm,
    input wen, ren, sen, ben, jen, jren, system, ecall, ebreak, mret, csr_cmd, csr,
    input trap, cause, tval,
    output ready
  );
endinterface

/* rv_compressed_expander.sv */
`timescale 1ns/1ps

module rv_compressed_expander
  import rv_decode_pkg::*;
(
  input  logic [15:0] cinst,
  output inst_t       inst
);
  reg_idx_t    rd_full;
  reg_idx_t    rs2_full;
  reg_idx_t    rd_p;
  reg_idx_t    rs1_p;
  logic [11:0] mem_off;
  logic [5:0]  imm6;
  logic [20:0] j_off;
  logic [12:0] b_off;

  assign rd_full  = cinst[11:7];
  assign rs2_full = cinst[6:2];
  assign rd_p     = {2'b01, cinst[4:2]};  // the short register fields only reach x8..x15
  assign rs1_p    = {2'b01, cinst[9:7]};
  assign imm6     = {cinst[12], cinst[6:2]};

  // word offset shared by c.lw and c.sw, zero extended
  assign mem_off = {5'b0, cinst[5], cinst[12:10], cinst[6], 2'b00};

  assign j_off = {{9{cinst[12]}}, cinst[12], cinst[8], cinst[10:9], cinst[6], cinst[7],
                  cinst[2], cinst[11], cinst[5:3], 1'b0};
  assign b_off = {{4{cinst[12]}}, cinst[12], cinst[6:5], cinst[2], cinst[11:10],
                  cinst[4:3], 1'b0};

  always_comb begin
    inst = '0;  // anything not handled below stays zero, which the decoder rejects
    case ({cinst[1:0], cinst[15:13]})
      5'b00_010: begin
        inst = {mem_off, rs1_p, 3'b010, rd_p, 7'b0000011};
      end
      5'b00_110: begin
        inst = {mem_off[11:5], rd_p, rs1_p, 3'b010, mem_off[4:0], 7'b0100011};
      end
      5'b01_000: begin
        // a zero rd or immediate is a nop or hint, not taken here
        if (rd_full != 5'd0 && imm6 != 6'd0) begin
          inst = {{6{imm6[5]}}, imm6, rd_full, 3'b000, rd_full, 7'b0010011};
        end
      end
      5'b01_010: begin
        inst = {{6{imm6[5]}}, imm6, 5'd0, 3'b000, rd_full, 7'b0010011};
      end
      5'b01_011: begin
        if (rd_full != 5'd0 && rd_full != 5'd2 && imm6 != 6'd0) begin  // rd x2 is c.addi16sp
          inst = {{14{imm6[5]}}, imm6, rd_full, 7'b0110111};
        end
      end
      5'b01_101: begin
        inst = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd0, 7'b1101111};
      end
      5'b01_110, 5'b01_111: begin
        // funct3 bit 0 picks bne over beq
        inst = {b_off[12], b_off[10:5], 5'd0, rs1_p, 2'b00, cinst[13], b_off[4:1],
                b_off[11], 7'b1100011};
      end
      5'b10_100: begin
        // rs2 of x0 is c.jr, c.jalr or c.ebreak
        if (rs2_full != 5'd0) begin
          inst = {7'b0, rs2_full, cinst[12] ? rd_full : 5'd0, 3'b000, rd_full, 7'b0110011};
        end
      end
      default: begin
        inst = '0;
      end
    endcase
  end

endmodule

/* rv_inst_decoder.sv */
`timescale 1ns/1ps

module rv_inst_decoder
  import rv_decode_pkg::*;
(
  input  inst_t       inst,
  output alu_op_e     alu,
  output reg_idx_t    rd,
  output reg_idx_t    rs1,
  output reg_idx_t    rs2,
  output logic [31:0] imm,
  output logic        wen,
  output logic        ren,
  output logic        sen,
  output logic        ben,
  output logic        jen,
  output logic        jren,
  output logic        system,
  output logic        ecall,
  output logic        ebreak,
  output logic        mret,
  output csr_cmd_t    csr_cmd,
  output csr_addr_t   csr
);
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  alu_op_e     base_alu;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign csr    = inst[31:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // register and immediate arithmetic share the funct3 map
  always_comb begin
    case (funct3)
      3'b000: base_alu = alu_add;
      3'b001: base_alu = alu_sll;
      3'b010: base_alu = alu_slt;
      3'b011: base_alu = alu_sltu;
      3'b100: base_alu = alu_xor;
      3'b101: base_alu = alu_srl;
      3'b110: base_alu = alu_or;
      default: base_alu = alu_and;
    endcase
  end

  always_comb begin
    alu     = alu_ill;
    imm     = '0;
    wen     = 1'b0;
    ren     = 1'b0;
    sen     = 1'b0;
    ben     = 1'b0;
    jen     = 1'b0;
    jren    = 1'b0;
    system  = 1'b0;
    ecall   = 1'b0;
    ebreak  = 1'b0;
    mret    = 1'b0;
    csr_cmd = '0;
    case (opcode)
      7'b0110111: begin
        alu = alu_lui;
        imm = imm_u;
        wen = 1'b1;
      end
      7'b0010111: begin
        alu = alu_auipc;
        imm = imm_u;
        wen = 1'b1;
      end
      7'b1101111: begin
        alu = alu_add;  // link value pc + 4
        imm = imm_j;
        wen = 1'b1;
        jen = 1'b1;
      end
      7'b1100111: begin
        alu  = (funct3 == 3'b000) ? alu_add : alu_ill;
        imm  = imm_i;
        wen  = 1'b1;
        jren = 1'b1;
      end
      7'b1100011: begin
        case (funct3[2:1])
          2'b00: alu = alu_sub;   // beq, bne
          2'b10: alu = alu_slt;   // blt, bge
          2'b11: alu = alu_sltu;  // bltu, bgeu
          default: alu = alu_ill;
        endcase
        imm = imm_b;
        ben = 1'b1;
      end
      7'b0000011: begin
        alu = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ? alu_add : alu_ill;
        imm = imm_i;
        wen = 1'b1;
        ren = 1'b1;
      end
      7'b0100011: begin
        alu = (funct3 inside {3'b000, 3'b001, 3'b010}) ? alu_add : alu_ill;
        imm = imm_s;
        sen = 1'b1;
      end
      7'b0010011: begin
        alu = base_alu;
        if (funct3 == 3'b001 && funct7 != 7'b0) begin
          alu = alu_ill;
        end else if (funct3 == 3'b101) begin
          alu = (funct7 == 7'b0) ? alu_srl : (funct7 == 7'b0100000) ? alu_sra : alu_ill;
        end
        imm = imm_i;
        wen = 1'b1;
      end
      7'b0110011: begin
        if (funct7 == 7'b0) begin
          alu = base_alu;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu = alu_sub;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          alu = alu_sra;
        end
        wen = 1'b1;
      end
      7'b1110011: begin
        system = 1'b1;
        if (funct3 == 3'b000) begin
          ecall  = inst == 32'h0000_0073;
          ebreak = inst == 32'h0010_0073;
          mret   = inst == 32'h3020_0073;
          alu    = (ecall || ebreak || mret) ? alu_pass : alu_ill;
        end else if (funct3 != 3'b100) begin
          alu     = alu_pass;
          csr_cmd = funct3;
          wen     = 1'b1;
          imm     = funct3[2] ? {27'b0, inst[19:15]} : '0;  // zimm of the immediate forms
        end
      end
      default: begin
        alu = alu_ill;
      end
    endcase
    // an undecodable word carries no side effects downstream
    if (alu == alu_ill) begin
      imm     = '0;
      wen     = 1'b0;
      ren     = 1'b0;
      sen     = 1'b0;
      ben     = 1'b0;
      jen     = 1'b0;
      jren    = 1'b0;
      system  = 1'b0;
      ecall   = 1'b0;
      ebreak  = 1'b0;
      mret    = 1'b0;
      csr_cmd = '0;
    end
  end

endmodule

/* rv_decode_stage.sv */
`timescale 1ns/1ps

module rv_decode_stage
  import rv_decode_pkg::*;
#(
  parameter bit s_mode_enable = 1'b1
) (
  input logic                clock,
  input logic                reset,
  input logic                flush,
  rv_fetch_decode_if.decode  fetch_decode,
  rv_decode_rename_if.decode decode_rename
);
  typedef enum logic {
    idle,
    holding
  } state_e;

  state_e    state;
  inst_t     held_inst;
  addr_t     held_pc;
  addr_t     held_pnpc;
  inst_t     c_inst;
  inst_t     dec_inst;
  alu_op_e   alu;
  reg_idx_t  rd;
  csr_cmd_t  csr_cmd;
  csr_addr_t csr;
  logic      in_ready;
  logic      accept;
  logic      is_c;
  logic      illegal_csr;
  logic      trap;

  function automatic logic csr_listed(csr_addr_t addr);
    case (addr)
      csr_mstatus, csr_misa, csr_medeleg, csr_mideleg, csr_mie, csr_mtvec,
      csr_mstatush, csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip,
      csr_mcycle, csr_mcycleh, csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid,
      csr_cycle, csr_time, csr_timeh:
        csr_listed = 1'b1;
      csr_sstatus, csr_sie, csr_stvec, csr_scounteren, csr_sscratch,
      csr_sepc, csr_scause, csr_stval, csr_sip, csr_satp:
        csr_listed = s_mode_enable;
      default:
        csr_listed = 1'b0;
    endcase
  endfunction

  // a new word may enter in the same cycle the held one leaves
  assign in_ready            = (state == idle) || decode_rename.ready;
  assign accept              = fetch_decode.valid && in_ready;
  assign fetch_decode.ready  = in_ready;
  assign decode_rename.valid = state == holding;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (!flush && fetch_decode.valid) state <= holding;
        end
        holding: begin
          if (flush) state <= idle;  // a word accepted alongside the flush is dropped as well
          else if (decode_rename.ready && !fetch_decode.valid) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held_inst <= fetch_decode.inst;
      held_pc   <= fetch_decode.pc;
      held_pnpc <= fetch_decode.pnpc;
    end
  end

  rv_compressed_expander u_expander (
    .cinst(held_inst[15:0]),
    .inst (c_inst)
  );

  assign is_c     = held_inst[1:0] != 2'b11;
  assign dec_inst = is_c ? c_inst : held_inst;

  rv_inst_decoder u_decoder (
    .inst   (dec_inst),
    .alu    (alu),
    .rd     (rd),
    .rs1    (decode_rename.rs1),
    .rs2    (decode_rename.rs2),
    .imm    (decode_rename.imm),
    .wen    (decode_rename.wen),
    .ren    (decode_rename.ren),
    .sen    (decode_rename.sen),
    .ben    (decode_rename.ben),
    .jen    (decode_rename.jen),
    .jren   (decode_rename.jren),
    .system (decode_rename.system),
    .ecall  (decode_rename.ecall),
    .ebreak (decode_rename.ebreak),
    .mret   (decode_rename.mret),
    .csr_cmd(csr_cmd),
    .csr    (csr)
  );

  assign illegal_csr = (csr_cmd != 3'b000) && !csr_listed(csr);
  assign trap        = (alu == alu_ill) || illegal_csr;

  assign decode_rename.is_c    = is_c;
  assign decode_rename.inst    = dec_inst;
  assign decode_rename.pc      = held_pc;
  assign decode_rename.pnpc    = held_pnpc;
  assign decode_rename.alu     = alu;
  assign decode_rename.rd      = trap ? 5'd0 : rd;  // a trapping word must not write back
  assign decode_rename.csr_cmd = csr_cmd;
  assign decode_rename.csr     = csr;
  assign decode_rename.trap    = trap;
  assign decode_rename.cause   = trap ? cause_illegal_inst : 4'd0;
  assign decode_rename.tval    = trap ? dec_inst : 32'd0;

  a_idle_after_reset : assert property (@(posedge clock) reset |=> !decode_rename.valid)
    else $error("decode output valid on the cycle after reset");

  a_stable_when_stalled : assert property (@(posedge clock) disable iff (reset)
      decode_rename.valid && !decode_rename.ready && !flush |=>
      $stable(decode_rename.inst) && $stable(decode_rename.pc) &&
      $stable(decode_rename.pnpc) && $stable(decode_rename.trap))
    else $error("decode payload changed while stalled by rename");

endmodule

/* rv_decode_top.sv */
`timescale 1ns/1ps

module rv_decode_top
  import rv_decode_pkg::*;
#(
  parameter bit s_mode_enable = 1'b1
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  logic        in_valid,
  input  inst_t       in_inst,
  input  addr_t       in_pc,
  input  addr_t       in_pnpc,
  input  logic        out_ready,
  output logic        in_ready,
  output logic        out_valid,
  output logic        out_is_c,
  output inst_t       out_inst,
  output addr_t       out_pc,
  output addr_t       out_pnpc,
  output alu_op_e     out_alu,
  output reg_idx_t    out_rd,
  output reg_idx_t    out_rs1,
  output reg_idx_t    out_rs2,
  output logic [31:0] out_imm,
  output logic        out_wen,
  output logic        out_ren,
  output logic        out_sen,
  output logic        out_ben,
  output logic        out_jen,
  output logic        out_jren,
  output logic        out_system,
  output logic        out_ecall,
  output logic        out_ebreak,
  output logic        out_mret,
  output csr_cmd_t    out_csr_cmd,
  output csr_addr_t   out_csr,
  output logic        out_trap,
  output cause_t      out_cause,
  output inst_t       out_tval
);
  rv_fetch_decode_if  fetch_decode ();
  rv_decode_rename_if decode_rename ();

  assign fetch_decode.valid  = in_valid;
  assign fetch_decode.inst   = in_inst;
  assign fetch_decode.pc     = in_pc;
  assign fetch_decode.pnpc   = in_pnpc;
  assign in_ready            = fetch_decode.ready;
  assign decode_rename.ready = out_ready;

  assign out_valid   = decode_rename.valid;
  assign out_is_c    = decode_rename.is_c;
  assign out_inst    = decode_rename.inst;
  assign out_pc      = decode_rename.pc;
  assign out_pnpc    = decode_rename.pnpc;
  assign out_alu     = decode_rename.alu;
  assign out_rd      = decode_rename.rd;
  assign out_rs1     = decode_rename.rs1;
  assign out_rs2     = decode_rename.rs2;
  assign out_imm     = decode_rename.imm;
  assign out_wen     = decode_rename.wen;
  assign out_ren     = decode_rename.ren;
  assign out_sen     = decode_rename.sen;
  assign out_ben     = decode_rename.ben;
  assign out_jen     = decode_rename.jen;
  assign out_jren    = decode_rename.jren;
  assign out_system  = decode_rename.system;
  assign out_ecall   = decode_rename.ecall;
  assign out_ebreak  = decode_rename.ebreak;
  assign out_mret    = decode_rename.mret;
  assign out_csr_cmd = decode_rename.csr_cmd;
  assign out_csr     = decode_rename.csr;
  assign out_trap    = decode_rename.trap;
  assign out_cause   = decode_rename.cause;
  assign out_tval    = decode_rename.tval;

  rv_decode_stage #(
    .s_mode_enable(s_mode_enable)
  ) u_stage (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .fetch_decode (fetch_decode.decode),
    .decode_rename(decode_rename.decode)
  );

endmodule

/* tb_rv_decode_checker.sv */
`timescale 1ns/1ps

module tb_rv_decode_checker
  import rv_decode_pkg::*;
#(
  parameter bit s_mode_enable = 1'b1
) (
  input logic clock, reset, flush, in_valid, out_ready, in_ready, out_valid, out_is_c,
  input inst_t in_inst, out_inst, out_tval,
  input addr_t in_pc, in_pnpc, out_pc, out_pnpc,
  input alu_op_e out_alu,
  input reg_idx_t out_rd, out_rs1, out_rs2,
  input logic [31:0] out_imm,
  input logic out_wen, out_ren, out_sen, out_ben, out_jen, out_jren,
  input logic out_system, out_ecall, out_ebreak, out_mret, out_trap,
  input csr_cmd_t out_csr_cmd,
  input csr_addr_t out_csr,
  input cause_t out_cause
);
  typedef struct packed {
    logic        is_c;
    inst_t       inst;
    addr_t       pc;
    addr_t       pnpc;
    alu_op_e     alu;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [31:0] imm;
    logic [9:0]  flags;  // wen ren sen ben jen jren system ecall ebreak mret
    csr_cmd_t    csr_cmd;
    csr_addr_t   csr;
    logic        trap;
    cause_t      cause;
    inst_t       tval;
  } rec_t;

  rec_t pending [$];
  rec_t expected;
  int   mismatches = 0;
  int   sequence_errors = 0;

  function automatic inst_t expand(input logic [15:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [31:0] simm;
    logic [6:0]  off;
    logic [20:0] j;
    logic [12:0] b;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[4:2]};
    rs1p = {2'b01, c[9:7]};
    simm = {{26{c[12]}}, c[12], c[6:2]};
    off  = {c[5], c[12:10], c[6], 2'b00};
    j    = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    b    = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    case ({c[1:0], c[15:13]})
      5'b00010: return {5'b0, off, rs1p, 3'b010, rdp, 7'h03};
      5'b00110: return {5'b0, off[6:5], rdp, rs1p, 3'b010, off[4:0], 7'h23};
      5'b01000: return (rd != 0 && simm != 0) ? {simm[11:0], rd, 3'b000, rd, 7'h13} : '0;
      5'b01010: return {simm[11:0], 5'd0, 3'b000, rd, 7'h13};
      5'b01011: return (rd != 0 && rd != 2 && simm != 0) ? {simm[19:0], rd, 7'h37} : '0;
      5'b01101: return {j[20], j[10:1], j[11], j[19:12], 5'd0, 7'h6f};
      5'b01110, 5'b01111: return {b[12], b[10:5], 5'd0, rs1p, 2'b00, c[13], b[4:1], b[11], 7'h63};
      5'b10100: return (rs2 != 0) ? {7'b0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33} : '0;
      default: return '0;
    endcase
  endfunction

  function automatic alu_op_e arith(input logic [2:0] f3);
    case (f3)
      3'd0: return alu_add;
      3'd1: return alu_sll;
      3'd2: return alu_slt;
      3'd3: return alu_sltu;
      3'd4: return alu_xor;
      3'd5: return alu_srl;
      3'd6: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic logic listed(input csr_addr_t a);
    case (a)
      12'h300, 12'h301, 12'h302, 12'h303, 12'h304, 12'h305, 12'h310, 12'h340, 12'h341,
      12'h342, 12'h343, 12'h344, 12'hb00, 12'hb80, 12'hf11, 12'hf12, 12'hf13, 12'hf14,
      12'hc00, 12'hc01, 12'hc81: return 1'b1;
      12'h100, 12'h104, 12'h105, 12'h106, 12'h140, 12'h141, 12'h142, 12'h143, 12'h144,
      12'h180: return s_mode_enable;
      default: return 1'b0;
    endcase
  endfunction

  function automatic rec_t reference(input inst_t raw, input addr_t pc, input addr_t pnpc);
    rec_t        r;
    inst_t       w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    r      = '0;
    r.is_c = raw[1:0] != 2'b11;
    w      = r.is_c ? expand(raw[15:0]) : raw;
    f3     = w[14:12];
    f7     = w[31:25];
    imm_i  = {{20{w[31]}}, w[31:20]};
    r.inst = w;
    r.pc   = pc;
    r.pnpc = pnpc;
    r.rd   = w[11:7];
    r.rs1  = w[19:15];
    r.rs2  = w[24:20];
    r.csr  = w[31:20];
    r.alu  = alu_ill;
    case (w[6:0])
      7'h37, 7'h17: begin
        r.alu   = w[5] ? alu_lui : alu_auipc;
        r.imm   = {w[31:12], 12'b0};
        r.flags = 10'b1000000000;
      end
      7'h6f: begin
        r.alu   = alu_add;
        r.imm   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        r.flags = 10'b1000100000;
      end
      7'h67: if (f3 == 0) begin
        r.alu   = alu_add;
        r.imm   = imm_i;
        r.flags = 10'b1000010000;
      end
      7'h63: if (f3 != 2 && f3 != 3) begin
        r.alu   = !f3[2] ? alu_sub : f3[1] ? alu_sltu : alu_slt;
        r.imm   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        r.flags = 10'b0001000000;
      end
      7'h03: if (f3 != 3 && f3 < 6) begin
        r.alu   = alu_add;
        r.imm   = imm_i;
        r.flags = 10'b1100000000;
      end
      7'h23: if (f3 < 3) begin
        r.alu   = alu_add;
        r.imm   = {{20{w[31]}}, w[31:25], w[11:7]};
        r.flags = 10'b0010000000;
      end
      7'h13: if (!((f3 == 1 && f7 != 0) || (f3 == 5 && f7 != 0 && f7 != 7'h20))) begin
        r.alu   = (f3 == 5 && f7[5]) ? alu_sra : arith(f3);
        r.imm   = imm_i;
        r.flags = 10'b1000000000;
      end
      7'h33: begin
        if (f7 == 0) r.alu = arith(f3);
        else if (f7 == 7'h20 && f3 == 0) r.alu = alu_sub;
        else if (f7 == 7'h20 && f3 == 5) r.alu = alu_sra;
        if (r.alu != alu_ill) r.flags = 10'b1000000000;
      end
      7'h73: begin
        if (w == 32'h00000073) r.flags = 10'b0000001100;
        else if (w == 32'h00100073) r.flags = 10'b0000001010;
        else if (w == 32'h30200073) r.flags = 10'b0000001001;
        else if (f3 != 0 && f3 != 4) begin
          r.flags   = 10'b1000001000;
          r.csr_cmd = f3;
          r.imm     = f3[2] ? {27'b0, w[19:15]} : 32'd0;
        end
        if (r.flags != 0) r.alu = alu_pass;
      end
      default: r.alu = alu_ill;
    endcase
    r.trap = (r.alu == alu_ill) || (r.csr_cmd != 0 && !listed(r.csr));
    if (r.trap) begin
      r.rd    = 5'd0;
      r.cause = 4'd2;
      r.tval  = w;
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("Error: %s expected 0x%h actual 0x%h at pc 0x%h", name, exp, act, out_pc);
    end
  endtask

  task automatic compare(input rec_t e);
    check("out_is_c", 32'(e.is_c), 32'(out_is_c));
    check("out_inst", e.inst, out_inst);
    check("out_pc", e.pc, out_pc);
    check("out_pnpc", e.pnpc, out_pnpc);
    check("out_alu", 32'(e.alu), 32'(out_alu));
    check("out_rd", 32'(e.rd), 32'(out_rd));
    check("out_rs1", 32'(e.rs1), 32'(out_rs1));
    check("out_rs2", 32'(e.rs2), 32'(out_rs2));
    check("out_imm", e.imm, out_imm);
    check("out_wen", 32'(e.flags[9]), 32'(out_wen));
    check("out_ren", 32'(e.flags[8]), 32'(out_ren));
    check("out_sen", 32'(e.flags[7]), 32'(out_sen));
    check("out_ben", 32'(e.flags[6]), 32'(out_ben));
    check("out_jen", 32'(e.flags[5]), 32'(out_jen));
    check("out_jren", 32'(e.flags[4]), 32'(out_jren));
    check("out_system", 32'(e.flags[3]), 32'(out_system));
    check("out_ecall", 32'(e.flags[2]), 32'(out_ecall));
    check("out_ebreak", 32'(e.flags[1]), 32'(out_ebreak));
    check("out_mret", 32'(e.flags[0]), 32'(out_mret));
    check("out_csr_cmd", 32'(e.csr_cmd), 32'(out_csr_cmd));
    check("out_csr", 32'(e.csr), 32'(out_csr));
    check("out_trap", 32'(e.trap), 32'(out_trap));
    check("out_cause", 32'(e.cause), 32'(out_cause));
    check("out_tval", e.tval, out_tval);
  endtask

  // the old record leaves before a new one enters on the same edge
  always @(posedge clock) begin
    if (!reset) begin
      // the stage holds a word exactly when a record is pending
      check("in_ready", 32'(pending.size() == 0 || out_ready), 32'(in_ready));
      check("out_valid", 32'(pending.size() != 0), 32'(out_valid));
      if (out_valid && out_ready) begin
        if (pending.size() == 0) begin
          sequence_errors++;
          $display("decode output taken with no instruction pending, pc 0x%h", out_pc);
        end else begin
          expected = pending.pop_front();
          compare(expected);
        end
      end else if (out_valid && pending.size() != 0) begin
        compare(pending[0]);  // a stalled record has to be right on every held cycle
      end
    end
    if (reset || flush) begin
      pending.delete();
    end else if (in_valid && in_ready) begin
      pending.push_back(reference(in_inst, in_pc, in_pnpc));
    end
  end

  task automatic final_report();
    if (pending.size() != 0) begin
      sequence_errors++;
      $display("%0d accepted instructions never left the decode stage", pending.size());
    end
    $display("checker: %0d field mismatches, %0d sequence errors", mismatches, sequence_errors);
  endtask

endmodule

/* tb_rv_decode.sv */
`timescale 1ns/1ps

module tb_rv_decode;
  import rv_decode_pkg::*;

  localparam int n_directed = 33;
  localparam int n_random   = 300;
  localparam int cycle_limit = 4 * (n_directed + n_random + 2) + 100;

  logic      clock;
  logic      reset;
  logic      flush;
  logic      in_valid;
  inst_t     in_inst;
  addr_t     in_pc;
  addr_t     in_pnpc;
  logic      out_ready;
  logic      in_ready;
  logic      out_valid;
  logic      out_is_c;
  inst_t     out_inst;
  addr_t     out_pc;
  addr_t     out_pnpc;
  alu_op_e   out_alu;
  reg_idx_t  out_rd;
  reg_idx_t  out_rs1;
  reg_idx_t  out_rs2;
  logic [31:0] out_imm;
  logic      out_wen;
  logic      out_ren;
  logic      out_sen;
  logic      out_ben;
  logic      out_jen;
  logic      out_jren;
  logic      out_system;
  logic      out_ecall;
  logic      out_ebreak;
  logic      out_mret;
  csr_cmd_t  out_csr_cmd;
  csr_addr_t out_csr;
  logic      out_trap;
  cause_t    out_cause;
  inst_t     out_tval;

  integer      seed;
  int unsigned cycles;
  logic        random_ready;
  addr_t       next_pc;
  inst_t       directed [0:n_directed-1] = '{
    32'h00500093, 32'hffb10093, 32'h40208033, 32'h0020d1b3, 32'h123450b7, 32'h00001217,
    32'h008000ef, 32'h00008067, 32'h00208463, 32'h0040a183, 32'h0030a223, 32'h4010d093,
    32'h00000073, 32'h00100073, 32'h30200073, 32'h300110f3, 32'h10002173, 32'h7c0010f3,
    32'hc0006173, 32'h0000007f, 32'h00000000, 32'hdead4501, 32'hbeef0505, 32'h00006505,
    32'h1234852e, 32'h0000952e, 32'h00004108, 32'hffffc108, 32'h0000a001, 32'h0000c111,
    32'h0000e111, 32'h00000001, 32'h00008082
  };
  logic [4:0]  c_kinds [0:8] = '{5'b00010, 5'b00110, 5'b01000, 5'b01010, 5'b01011,
                                 5'b01101, 5'b01110, 5'b01111, 5'b10100};
  logic [6:0]  opcodes [0:9] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
                                 7'h13, 7'h33, 7'h73};

  rv_decode_top #(.s_mode_enable(1'b1)) DUT (.*);

  tb_rv_decode_checker #(.s_mode_enable(1'b1)) u_checker (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // rename stalls about a third of the cycles while random_ready is set
  task automatic drive_random_ready();
    if (random_ready) out_ready = ({$random(seed)} % 3) != 0;
  endtask

  task automatic send(input inst_t word, input logic with_flush);
    in_valid = 1'b1;
    in_inst  = word;
    in_pc    = next_pc;
    in_pnpc  = next_pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
    flush    = with_flush;
    @(posedge clock);
    while (!in_ready) begin
      #1;
      flush = 1'b0;
      drive_random_ready();
      @(posedge clock);
    end
    #1;
    flush    = 1'b0;
    in_valid = 1'b0;
    next_pc  = in_pnpc;
    drive_random_ready();
  endtask

  function automatic inst_t random_word(input logic [31:0] r, input logic [31:0] s);
    logic [4:0] kind;
    if (r[0]) begin
      kind = c_kinds[s[7:0] % 9];
      return {s[31:16], kind[2:0], r[12:2], kind[4:3]};
    end
    return {r[31:7], opcodes[s[7:0] % 10]};
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    logic        do_flush;
    seed         = 14162;
    cycles       = 0;
    reset        = 1'b1;
    flush        = 1'b0;
    in_valid     = 1'b0;
    in_inst      = '0;
    in_pc        = '0;
    in_pnpc      = '0;
    out_ready    = 1'b1;
    random_ready = 1'b0;
    next_pc      = 32'h0000_1000;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < n_directed; i++) send(directed[i], 1'b0);

    // let the last directed word leave so the stage starts empty
    @(posedge clock);
    #1;

    // hold one word under back-pressure, then flush it away
    out_ready = 1'b0;
    send(32'h00a00513, 1'b0);
    send(32'h00b00593, 1'b1);
    out_ready = 1'b1;

    random_ready = 1'b1;
    for (int i = 0; i < n_random; i++) begin
      r        = $random(seed);
      s        = $random(seed);
      do_flush = (s[11:8] == 4'd0);
      send(random_word(r, s), do_flush);
    end
    random_ready = 1'b0;
    out_ready    = 1'b1;

    @(posedge clock);
    while (out_valid) @(posedge clock);
    @(posedge clock);
    #1;
    u_checker.final_report();
    if (u_checker.mismatches == 0 && u_checker.sequence_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
rv_decode_pkg.sv
rv_fetch_decode_if.sv
rv_decode_rename_if.sv
rv_compressed_expander.sv
rv_inst_decoder.sv
rv_decode_stage.sv
rv_decode_top.sv
tb_rv_decode_checker.sv
tb_rv_decode.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_decode
FILELIST  := src.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "no pass result in log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
